/* pkt_sched.f */
hw/pkt_sched_pkg.sv
hw/slot_desc_fifo.sv
hw/rx_dest_tagger.sv
hw/desc_return_arbiter.sv
hw/core_reset_seq.sv
hw/pkt_sched.sv
tests/pkt_sched_assertions.sv
tests/pkt_sched_tb.sv

/* Makefile */
# Verilator flow for the packet scheduler

VERILATOR ?= verilator
TOP       ?= pkt_sched_tb
RTL_TOP   ?= pkt_sched
FILELIST  ?= pkt_sched.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tests/pkt_sched_tb.sv */
`timescale 1ns/1ps

module pkt_sched_tb;

  localparam int PC = pkt_sched_pkg::PORT_COUNT;
  localparam int DW = pkt_sched_pkg::DATA_WIDTH;
  localparam int KW = pkt_sched_pkg::KEEP_WIDTH;
  localparam int SW = pkt_sched_pkg::DESC_WIDTH;
  localparam int CW = pkt_sched_pkg::CORE_ID_WIDTH;

  typedef enum {OP_RX, OP_TX, OP_COLLIDE, OP_CTRL} op_e;
  typedef struct {
    op_e         op;
    int          port;
    int          beats;
    logic [63:0] data;
    logic [15:0] len;
  } step_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic [PC*DW-1:0] rx_tdata, tx_tdata, data_m_tdata, data_s_tdata;
  logic [PC*KW-1:0] rx_tkeep, tx_tkeep, data_m_tkeep, data_s_tkeep;
  logic [PC*SW-1:0] data_m_tdest, data_s_tuser;
  logic [PC-1:0]    rx_tvalid, rx_tlast, rx_tready, tx_tvalid, tx_tlast, tx_tready;
  logic [PC-1:0]    data_m_tvalid, data_m_tlast, data_m_tready;
  logic [PC-1:0]    data_s_tvalid, data_s_tlast, data_s_tready;
  logic [DW-1:0]    ctrl_m_tdata, ctrl_s_tdata;
  logic [CW-1:0]    ctrl_m_tdest, ctrl_s_tuser;
  logic             ctrl_m_tvalid, ctrl_m_tlast, ctrl_m_tready;
  logic             ctrl_s_tvalid, ctrl_s_tlast, ctrl_s_tready;

  step_t        steps[$];
  logic [SW-1:0] ref_q[$];
  logic [SW-1:0] consumed[$];
  logic [SW-1:0] held_ref[PC];
  int           collide_cnt = 0;
  int           error_count = 0;
  int           cycle_cnt = 0;

  pkt_sched pkt_sched_i (.*);

  always #5 clk = ~clk;

  // Run limit scales with the table length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= steps.size() * 40 + 200) begin
      $display("timeout after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  function automatic void fail_now();
    error_count++;
    $display("TEST FAILED");
    $fatal(1);
  endfunction

  task automatic check_desc(string name, logic [SW-1:0] got, logic [SW-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_data(string name, logic [DW-1:0] got_d, logic [DW-1:0] exp_d,
                            logic [KW-1:0] got_k, logic [KW-1:0] exp_k);
    if (got_d !== exp_d || got_k !== exp_k) begin
      $display("mismatch %s: got %h/%h expected %h/%h", name, got_d, got_k, exp_d, exp_k);
      fail_now();
    end
  endtask

  task automatic check_ctrl(logic [CW-1:0] got_dest, logic [CW-1:0] exp_dest,
                            logic [DW-1:0] got_data, logic got_last);
    if (got_dest !== exp_dest || got_data !== pkt_sched_pkg::CORE_RESET_CMD ||
        got_last !== 1'b1) begin
      $display("mismatch ctrl_m: got %h/%h/%h expected %h/%h/1", got_dest, got_data,
               got_last, exp_dest, pkt_sched_pkg::CORE_RESET_CMD);
      fail_now();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic add_step(op_e op, int port, int beats, logic [63:0] data, logic [15:0] len);
    step_t s;
    s.op = op;
    s.port = port;
    s.beats = beats;
    s.data = data;
    s.len = len;
    steps.push_back(s);
  endtask

  function automatic logic [SW-1:0] next_free();
    if (ref_q.size() == 0) begin
      $display("reference descriptor queue ran empty");
      fail_now();
    end
    return ref_q.pop_front();
  endfunction

  task automatic check_reset_cmds();
    int n;
    n = 0;
    while (n < pkt_sched_pkg::CORE_COUNT) begin
      ctrl_m_tready = 1'($urandom % 2);
      #4;
      check_flag("ctrl_m_tvalid", ctrl_m_tvalid, 1'b1);
      if (ctrl_m_tready) begin
        check_ctrl(ctrl_m_tdest, CW'(n), ctrl_m_tdata, ctrl_m_tlast);
        n++;
      end
      next_cycle();
    end
    #4;
    check_flag("ctrl_m_tvalid", ctrl_m_tvalid, 1'b0);
    next_cycle();
  endtask

  task automatic run_rx(int p, int beats, logic [63:0] base);
    logic [SW-1:0] exp_dest;
    logic [DW-1:0] d;
    logic [KW-1:0] k;
    int b;
    exp_dest = held_ref[p];
    b = 0;
    while (b < beats) begin
      d = base + 64'(b);
      k = (b == beats - 1) ? 8'h0F : 8'hFF;
      rx_tdata[p*DW +: DW] = d;
      rx_tkeep[p*KW +: KW] = k;
      rx_tlast[p] = (b == beats - 1);
      rx_tvalid[p] = 1'b1;
      data_m_tready[p] = 1'($urandom % 2);
      #4;
      if (!data_m_tready[p]) begin
        check_flag("rx_tready", rx_tready[p], 1'b0);
        if (data_m_tvalid[p]) begin
          check_desc("data_m_tdest", data_m_tdest[p*SW +: SW], exp_dest);
        end
      end else if (data_m_tvalid[p]) begin
        check_data("data_m_tdata", data_m_tdata[p*DW +: DW], d, data_m_tkeep[p*KW +: KW], k);
        check_desc("data_m_tdest", data_m_tdest[p*SW +: SW], exp_dest);
        check_flag("data_m_tlast", data_m_tlast[p], b == beats - 1);
        b++;
      end
      next_cycle();
    end
    rx_tvalid[p] = 1'b0;
    rx_tlast[p] = 1'b0;
    data_m_tready[p] = 1'b0;
    // Port reloads from the head right as its last beat goes through
    held_ref[p] = next_free();
    consumed.push_back(exp_dest);
  endtask

  task automatic run_tx(int p, int beats, logic [63:0] base);
    logic [SW-1:0] dsc;
    logic [DW-1:0] d;
    int b;
    dsc = consumed.pop_front();
    b = 0;
    while (b < beats) begin
      d = base + 64'(b);
      data_s_tdata[p*DW +: DW] = d;
      data_s_tkeep[p*KW +: KW] = 8'hFF;
      data_s_tuser[p*SW +: SW] = dsc;
      data_s_tlast[p] = (b == beats - 1);
      data_s_tvalid[p] = 1'b1;
      #4;
      if (data_s_tready[p]) begin
        check_flag("tx_tvalid", tx_tvalid[p], 1'b1);
        check_data("tx_tdata", tx_tdata[p*DW +: DW], d, tx_tkeep[p*KW +: KW], 8'hFF);
        check_flag("tx_tlast", tx_tlast[p], b == beats - 1);
        if (b == beats - 1) begin
          ref_q.push_back(dsc);
        end
        b++;
      end
      next_cycle();
    end
    data_s_tvalid[p] = 1'b0;
    data_s_tlast[p] = 1'b0;
  endtask

  task automatic run_collide(logic [63:0] base);
    logic [SW-1:0] dsc[PC];
    int first;
    dsc[0] = consumed.pop_front();
    dsc[1] = consumed.pop_front();
    // Port 0 wins the first collision, then the winner alternates
    first = collide_cnt % 2;
    for (int l = 0; l < PC; l++) begin
      data_s_tdata[l*DW +: DW] = base + 64'(l);
      data_s_tkeep[l*KW +: KW] = 8'hFF;
      data_s_tuser[l*SW +: SW] = dsc[l];
    end
    data_s_tlast = '1;
    data_s_tvalid = '1;
    #4;
    check_flag("data_s_tready winner", data_s_tready[first], 1'b1);
    check_flag("data_s_tready loser", data_s_tready[1-first], 1'b0);
    check_flag("tx_tvalid loser", tx_tvalid[1-first], 1'b0);
    ref_q.push_back(dsc[first]);
    next_cycle();
    data_s_tvalid[first] = 1'b0;
    #4;
    check_flag("data_s_tready loser", data_s_tready[1-first], 1'b1);
    ref_q.push_back(dsc[1-first]);
    next_cycle();
    data_s_tvalid = '0;
    data_s_tlast = '0;
    collide_cnt++;
  endtask

  task automatic run_ctrl(logic [15:0] len);
    logic [SW-1:0] dsc;
    logic done;
    dsc = consumed[0];
    // Only a zero-length message gives its slot back
    if (len == 16'h0) begin
      void'(consumed.pop_front());
    end
    ctrl_s_tdata = {40'h0, dsc[7:0], len};
    ctrl_s_tuser = dsc[SW-1:SW-CW];
    ctrl_s_tlast = 1'b1;
    ctrl_s_tvalid = 1'b1;
    done = 1'b0;
    while (!done) begin
      #4;
      done = ctrl_s_tready;
      next_cycle();
    end
    ctrl_s_tvalid = 1'b0;
    // A latched message holds off the next one until it is pushed
    #4;
    check_flag("ctrl_s_tready", ctrl_s_tready, len != 16'h0);
    next_cycle();
    if (len == 16'h0) begin
      ref_q.push_back(dsc);
    end
  endtask

  initial begin
    void'($urandom(32'h29832160));
    rx_tdata = '0;
    rx_tkeep = '0;
    rx_tvalid = '0;
    rx_tlast = '0;
    tx_tready = '1;
    data_m_tready = '0;
    data_s_tdata = '0;
    data_s_tkeep = '0;
    data_s_tuser = '0;
    data_s_tvalid = '0;
    data_s_tlast = '0;
    ctrl_m_tready = 1'b0;
    ctrl_s_tdata = '0;
    ctrl_s_tuser = '0;
    ctrl_s_tvalid = 1'b0;
    ctrl_s_tlast = 1'b0;

    // Preload order of the FIFO, slot-major
    for (int i = 0; i < pkt_sched_pkg::DESC_TOTAL; i++) begin
      ref_q.push_back({CW'(i % pkt_sched_pkg::CORE_COUNT),
                       8'h20 + 8'(i / pkt_sched_pkg::CORE_COUNT) * 8'h08});
    end
    held_ref[0] = ref_q.pop_front();
    held_ref[1] = ref_q.pop_front();

    for (int i = 0; i < 4; i++) begin
      add_step(OP_RX, i % 2, 4 - i, 64'h1000_0000_0000_0100 * (i + 1), 0);
    end
    add_step(OP_TX, 0, 2, 64'h2000_0000_0000_0000, 0);
    add_step(OP_TX, 1, 1, 64'h2100_0000_0000_0000, 0);
    add_step(OP_COLLIDE, 0, 1, 64'h3000_0000_0000_0000, 0);
    for (int i = 0; i < 4; i++) begin
      add_step(OP_RX, i % 2, 2, 64'h4000_0000_0000_0100 * (i + 1), 0);
    end
    add_step(OP_CTRL, 0, 1, 0, 16'h0000);
    add_step(OP_CTRL, 0, 1, 0, 16'h0005);
    add_step(OP_COLLIDE, 0, 1, 64'h5000_0000_0000_0000, 0);
    add_step(OP_TX, 1, 3, 64'h5100_0000_0000_0000, 0);
    // Enough packets to reach the control and second collision returns
    for (int i = 0; i < 14; i++) begin
      add_step(OP_RX, i % 2, 1 + i % 3, 64'h6000_0000_0001_0000 * (i + 1), 0);
    end

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_cmds();

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_RX:      run_rx(steps[i].port, steps[i].beats, steps[i].data);
        OP_TX:      run_tx(steps[i].port, steps[i].beats, steps[i].data);
        OP_COLLIDE: run_collide(steps[i].data);
        default:    run_ctrl(steps[i].len);
      endcase
    end

    if (error_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

/* tests/pkt_sched_assertions.sv */
`timescale 1ns/1ps

module pkt_sched_assertions (
  input logic                                  clk,
  input logic                                  rst,
  input logic [pkt_sched_pkg::PORT_COUNT-1:0]  rx_tvalid,
  input logic [pkt_sched_pkg::PORT_COUNT-1:0]  data_m_tvalid,
  input logic [pkt_sched_pkg::PORT_COUNT-1:0]  data_s_tvalid,
  input logic [pkt_sched_pkg::PORT_COUNT-1:0]  data_s_tready,
  input logic [pkt_sched_pkg::PORT_COUNT-1:0]  data_s_tlast,
  input logic                                  ctrl_m_tvalid,
  input logic                                  desc_in_valid
);

  // Cycles since reset, saturating once the preload is over
  int fill_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_cnt <= 0;
    end else if (fill_cnt < pkt_sched_pkg::DESC_TOTAL) begin
      fill_cnt <= fill_cnt + 1;
    end
  end

  rx_valid_gated: assert property (@(posedge clk) disable iff (rst)
    (data_m_tvalid & ~rx_tvalid) == '0)
    else $error("data_m_tvalid high without rx_tvalid");

  one_release: assert property (@(posedge clk) disable iff (rst)
    $onehot0(data_s_tvalid & data_s_tready & data_s_tlast))
    else $error("two transmit lanes took a last beat in one cycle");

  reset_cmd_once: assert property (@(posedge clk) disable iff (rst)
    !ctrl_m_tvalid |=> !ctrl_m_tvalid)
    else $error("ctrl_m_tvalid rose again");

  no_push_in_fill: assert property (@(posedge clk) disable iff (rst)
    (fill_cnt < pkt_sched_pkg::DESC_TOTAL) |-> !desc_in_valid)
    else $error("descriptor pushed during the preload");

endmodule

bind pkt_sched pkt_sched_assertions pkt_sched_assertions_i (
  .clk           (clk),
  .rst           (rst),
  .rx_tvalid     (rx_tvalid),
  .data_m_tvalid (data_m_tvalid),
  .data_s_tvalid (data_s_tvalid),
  .data_s_tready (data_s_tready),
  .data_s_tlast  (data_s_tlast),
  .ctrl_m_tvalid (ctrl_m_tvalid),
  .desc_in_valid (desc_in_valid)
);

/* hw/pkt_sched.sv */
`timescale 1ns/1ps

module pkt_sched (
  input  logic clk,
  input  logic rst,

  // Ethernet receive
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] rx_tdata,
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] rx_tkeep,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           rx_tvalid,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           rx_tlast,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           rx_tready,

  // Ethernet transmit
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] tx_tdata,
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] tx_tkeep,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           tx_tvalid,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           tx_tlast,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           tx_tready,

  // Data toward the cores
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] data_m_tdata,
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] data_m_tkeep,
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DESC_WIDTH-1:0] data_m_tdest,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_m_tvalid,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_m_tlast,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_m_tready,

  // Data from the cores
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] data_s_tdata,
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] data_s_tkeep,
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DESC_WIDTH-1:0] data_s_tuser,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_s_tvalid,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_s_tlast,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_s_tready,

  // Control toward the cores
  output logic [pkt_sched_pkg::DATA_WIDTH-1:0]                           ctrl_m_tdata,
  output logic [pkt_sched_pkg::CORE_ID_WIDTH-1:0]                        ctrl_m_tdest,
  output logic                                                           ctrl_m_tvalid,
  output logic                                                           ctrl_m_tlast,
  input  logic                                                           ctrl_m_tready,

  // Control from the cores
  input  logic [pkt_sched_pkg::DATA_WIDTH-1:0]                           ctrl_s_tdata,
  input  logic [pkt_sched_pkg::CORE_ID_WIDTH-1:0]                        ctrl_s_tuser,
  input  logic                                                           ctrl_s_tvalid,
  input  logic                                                           ctrl_s_tlast,
  output logic                                                           ctrl_s_tready
);

  logic                                 desc_out_valid;
  logic [pkt_sched_pkg::DESC_WIDTH-1:0] desc_out;
  logic                                 desc_out_ready;
  logic                                 desc_in_valid;
  logic [pkt_sched_pkg::DESC_WIDTH-1:0] desc_in;

  slot_desc_fifo slot_desc_fifo_i (
    .clk            (clk),
    .rst            (rst),
    .desc_in_valid  (desc_in_valid),
    .desc_in        (desc_in),
    .desc_out_valid (desc_out_valid),
    .desc_out       (desc_out),
    .desc_out_ready (desc_out_ready)
  );

  rx_dest_tagger rx_dest_tagger_i (
    .clk           (clk),
    .rst           (rst),
    .rx_tdata      (rx_tdata),
    .rx_tkeep      (rx_tkeep),
    .rx_tvalid     (rx_tvalid),
    .rx_tlast      (rx_tlast),
    .rx_tready     (rx_tready),
    .data_m_tdata  (data_m_tdata),
    .data_m_tkeep  (data_m_tkeep),
    .data_m_tdest  (data_m_tdest),
    .data_m_tvalid (data_m_tvalid),
    .data_m_tlast  (data_m_tlast),
    .data_m_tready (data_m_tready),
    .desc_valid    (desc_out_valid),
    .desc          (desc_out),
    .desc_pop      (desc_out_ready)
  );

  desc_return_arbiter desc_return_arbiter_i (
    .clk           (clk),
    .rst           (rst),
    .data_s_tdata  (data_s_tdata),
    .data_s_tkeep  (data_s_tkeep),
    .data_s_tuser  (data_s_tuser),
    .data_s_tvalid (data_s_tvalid),
    .data_s_tlast  (data_s_tlast),
    .data_s_tready (data_s_tready),
    .tx_tdata      (tx_tdata),
    .tx_tkeep      (tx_tkeep),
    .tx_tvalid     (tx_tvalid),
    .tx_tlast      (tx_tlast),
    .tx_tready     (tx_tready),
    .ctrl_s_tdata  (ctrl_s_tdata),
    .ctrl_s_tuser  (ctrl_s_tuser),
    .ctrl_s_tvalid (ctrl_s_tvalid),
    .ctrl_s_tlast  (ctrl_s_tlast),
    .ctrl_s_tready (ctrl_s_tready),
    .desc_in_valid (desc_in_valid),
    .desc_in       (desc_in)
  );

  core_reset_seq core_reset_seq_i (
    .clk           (clk),
    .rst           (rst),
    .ctrl_m_tdata  (ctrl_m_tdata),
    .ctrl_m_tdest  (ctrl_m_tdest),
    .ctrl_m_tvalid (ctrl_m_tvalid),
    .ctrl_m_tlast  (ctrl_m_tlast),
    .ctrl_m_tready (ctrl_m_tready)
  );

endmodule

/* hw/core_reset_seq.sv */
`timescale 1ns/1ps

module core_reset_seq (
  input  logic                                   clk,
  input  logic                                   rst,

  // Control stream toward the cores
  output logic [pkt_sched_pkg::DATA_WIDTH-1:0]    ctrl_m_tdata,
  output logic [pkt_sched_pkg::CORE_ID_WIDTH-1:0] ctrl_m_tdest,
  output logic                                   ctrl_m_tvalid,
  output logic                                   ctrl_m_tlast,
  input  logic                                   ctrl_m_tready
);

  // Extra bit lets the counter reach CORE_COUNT and stop there
  logic [pkt_sched_pkg::CORE_ID_WIDTH:0] core_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      core_cnt <= '0;
    end else if (ctrl_m_tvalid && ctrl_m_tready) begin
      core_cnt <= core_cnt + 1'b1;
    end
  end

  assign ctrl_m_tvalid = (core_cnt < pkt_sched_pkg::CORE_COUNT);
  assign ctrl_m_tdest  = core_cnt[pkt_sched_pkg::CORE_ID_WIDTH-1:0];
  assign ctrl_m_tdata  = pkt_sched_pkg::CORE_RESET_CMD;
  // Single-beat command
  assign ctrl_m_tlast  = 1'b1;

endmodule

/* hw/desc_return_arbiter.sv */
`timescale 1ns/1ps

module desc_return_arbiter (
  input  logic clk,
  input  logic rst,

  // Core streams to be transmitted
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] data_s_tdata,
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] data_s_tkeep,
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DESC_WIDTH-1:0] data_s_tuser,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_s_tvalid,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_s_tlast,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_s_tready,

  // Ethernet transmit side
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] tx_tdata,
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] tx_tkeep,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           tx_tvalid,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           tx_tlast,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           tx_tready,

  // Control messages from the cores
  input  logic [pkt_sched_pkg::DATA_WIDTH-1:0]                           ctrl_s_tdata,
  input  logic [pkt_sched_pkg::CORE_ID_WIDTH-1:0]                        ctrl_s_tuser,
  input  logic                                                           ctrl_s_tvalid,
  input  logic                                                           ctrl_s_tlast,
  output logic                                                           ctrl_s_tready,

  // Push port of the descriptor FIFO
  output logic                                                           desc_in_valid,
  output logic [pkt_sched_pkg::DESC_WIDTH-1:0]                           desc_in
);

  logic [pkt_sched_pkg::PORT_COUNT-1:0] release_req;
  logic [pkt_sched_pkg::PORT_COUNT-1:0] stall;
  logic                                 favour_p1;
  logic                                 sel;
  logic                                 tx_release;
  logic [pkt_sched_pkg::DESC_WIDTH-1:0] tx_desc;

  logic                                 ctrl_pending;
  logic [pkt_sched_pkg::DESC_WIDTH-1:0] ctrl_desc;
  logic                                 zero_len_msg;

  // Last beats that the Ethernet side can take this cycle
  assign release_req = data_s_tvalid & data_s_tlast & tx_tready;

  // On a collision the lane not selected waits one cycle
  always_comb begin
    stall = '0;
    sel   = release_req[1] && !release_req[0];
    if (&release_req) begin
      sel   = favour_p1;
      stall = favour_p1 ? 2'b01 : 2'b10;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      favour_p1 <= 1'b0;
    end else if (&release_req) begin
      favour_p1 <= ~favour_p1;
    end
  end

  // Stalled lane is held on both sides so the beat is not duplicated
  assign tx_tdata      = data_s_tdata;
  assign tx_tkeep      = data_s_tkeep;
  assign tx_tlast      = data_s_tlast;
  assign tx_tvalid     = data_s_tvalid & ~stall;
  assign data_s_tready = tx_tready & ~stall;

  assign tx_release = |release_req;
  assign tx_desc    = data_s_tuser[sel*pkt_sched_pkg::DESC_WIDTH +: pkt_sched_pkg::DESC_WIDTH];

  // Only length-zero messages free a slot, others are consumed and dropped
  assign ctrl_s_tready = !ctrl_pending;
  assign zero_len_msg  = ctrl_s_tvalid && ctrl_s_tready && ctrl_s_tlast &&
                         (ctrl_s_tdata[pkt_sched_pkg::LEN_WIDTH-1:0] == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_pending <= 1'b0;
    end else if (zero_len_msg) begin
      ctrl_pending <= 1'b1;
    end else if (!tx_release) begin
      ctrl_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (zero_len_msg) begin
      ctrl_desc <= {ctrl_s_tuser,
                    ctrl_s_tdata[pkt_sched_pkg::CTRL_SLOT_LSB +: pkt_sched_pkg::SLOT_ADDR_WIDTH]};
    end
  end

  // Transmit releases go first, the control descriptor fills idle cycles
  assign desc_in_valid = tx_release || ctrl_pending;
  assign desc_in       = tx_release ? tx_desc : ctrl_desc;

endmodule

/* hw/rx_dest_tagger.sv */
`timescale 1ns/1ps

module rx_dest_tagger (
  input  logic clk,
  input  logic rst,

  // Receive streams from the Ethernet ports
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] rx_tdata,
  input  logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] rx_tkeep,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           rx_tvalid,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           rx_tlast,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           rx_tready,

  // Tagged streams toward the cores
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DATA_WIDTH-1:0] data_m_tdata,
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::KEEP_WIDTH-1:0] data_m_tkeep,
  output logic [pkt_sched_pkg::PORT_COUNT*pkt_sched_pkg::DESC_WIDTH-1:0] data_m_tdest,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_m_tvalid,
  output logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_m_tlast,
  input  logic [pkt_sched_pkg::PORT_COUNT-1:0]                           data_m_tready,

  // Free descriptor head of the FIFO
  input  logic                                                           desc_valid,
  input  logic [pkt_sched_pkg::DESC_WIDTH-1:0]                           desc,
  output logic                                                           desc_pop
);

  logic [pkt_sched_pkg::DESC_WIDTH-1:0] dest_q [pkt_sched_pkg::PORT_COUNT];
  logic [pkt_sched_pkg::PORT_COUNT-1:0] held;
  logic [pkt_sched_pkg::PORT_COUNT-1:0] last_accept;
  logic [pkt_sched_pkg::PORT_COUNT-1:0] need;

  assign last_accept = rx_tvalid & rx_tlast & rx_tready;

  // A port needs a new descriptor when empty or finishing its packet
  assign need     = ~held | last_accept;
  assign desc_pop = |need;

  // Port 0 wins when both ports need a descriptor in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      held <= '0;
    end else if (need[0]) begin
      held[0] <= desc_valid;
      // Port 1 gets its turn on the next cycle
      if (last_accept[1]) begin
        held[1] <= 1'b0;
      end
    end else if (need[1]) begin
      held[1] <= desc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (need[0]) begin
      dest_q[0] <= desc;
    end else if (need[1]) begin
      dest_q[1] <= desc;
    end
  end

  // No packet may start until a descriptor is held
  assign data_m_tvalid = rx_tvalid & held;
  assign rx_tready     = data_m_tready & held;

  assign data_m_tdata  = rx_tdata;
  assign data_m_tkeep  = rx_tkeep;
  assign data_m_tlast  = rx_tlast;
  assign data_m_tdest  = {dest_q[1], dest_q[0]};

endmodule

/* hw/slot_desc_fifo.sv */
`timescale 1ns/1ps

module slot_desc_fifo (
  input  logic                                clk,
  input  logic                                rst,

  // Returned descriptors
  input  logic                                desc_in_valid,
  input  logic [pkt_sched_pkg::DESC_WIDTH-1:0] desc_in,

  // Free descriptors toward the receive tagger
  output logic                                desc_out_valid,
  output logic [pkt_sched_pkg::DESC_WIDTH-1:0] desc_out,
  input  logic                                desc_out_ready
);

  pkt_sched_pkg::fifo_state_e state;

  logic [pkt_sched_pkg::DESC_WIDTH-1:0] mem [pkt_sched_pkg::DESC_TOTAL];

  logic [pkt_sched_pkg::DESC_PTR_WIDTH-1:0] wr_ptr;
  logic [pkt_sched_pkg::DESC_PTR_WIDTH-1:0] rd_ptr;
  logic [pkt_sched_pkg::DESC_PTR_WIDTH:0]   count;

  logic                                     push;
  logic                                     pop;
  logic [pkt_sched_pkg::DESC_WIDTH-1:0]     wr_data;

  // Preload row and slot address derived from the write pointer
  logic [pkt_sched_pkg::SLOT_ADDR_WIDTH-1:0] fill_row;
  logic [pkt_sched_pkg::SLOT_ADDR_WIDTH-1:0] fill_addr;

  // Slot-major order, so the low bits give the core and the rest the row
  assign fill_row = {
    {(pkt_sched_pkg::SLOT_ADDR_WIDTH - pkt_sched_pkg::DESC_PTR_WIDTH
      + pkt_sched_pkg::CORE_ID_WIDTH){1'b0}},
    wr_ptr[pkt_sched_pkg::DESC_PTR_WIDTH-1:pkt_sched_pkg::CORE_ID_WIDTH]
  };
  assign fill_addr = pkt_sched_pkg::SLOT_START_ADDR + fill_row * pkt_sched_pkg::SLOT_ADDR_STEP;

  // External pushes are only taken once the preload is done
  assign push = (state == pkt_sched_pkg::FIFO_FILL) || desc_in_valid;
  assign pop  = desc_out_valid && desc_out_ready;

  assign wr_data = (state == pkt_sched_pkg::FIFO_FILL) ?
                   {wr_ptr[pkt_sched_pkg::CORE_ID_WIDTH-1:0], fill_addr} : desc_in;

  // First-word-fall-through head
  assign desc_out_valid = (count != '0);
  assign desc_out       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= pkt_sched_pkg::FIFO_FILL;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == pkt_sched_pkg::DESC_TOTAL - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == pkt_sched_pkg::DESC_TOTAL - 1) ? '0 : rd_ptr + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // Last preload write wraps the pointer back to slot 0
      if (state == pkt_sched_pkg::FIFO_FILL &&
          wr_ptr == pkt_sched_pkg::DESC_TOTAL - 1) begin
        state <= pkt_sched_pkg::FIFO_RUN;
      end
    end
  end

endmodule

/* hw/pkt_sched_pkg.sv */
package pkt_sched_pkg;

  // Ethernet ports and cores
  localparam int PORT_COUNT = 2;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;

  // Stream widths
  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  // Length field sits in the low bits of a control message
  localparam int LEN_WIDTH = 16;

  // Slot layout inside each core's packet memory
  localparam int SLOT_ADDR_WIDTH = 8;
  localparam logic [SLOT_ADDR_WIDTH-1:0] SLOT_START_ADDR = 8'h20;
  localparam logic [SLOT_ADDR_WIDTH-1:0] SLOT_ADDR_STEP = 8'h08;

  // Descriptor is {core, slot address}
  localparam int CORE_ID_WIDTH = 2;
  localparam int DESC_WIDTH = CORE_ID_WIDTH + SLOT_ADDR_WIDTH;
  localparam int DESC_TOTAL = CORE_COUNT * SLOT_COUNT;
  localparam int DESC_PTR_WIDTH = $clog2(DESC_TOTAL);

  // Slot address position in a control message
  localparam int CTRL_SLOT_LSB = 16;

  // Command word sent to every core once after reset
  localparam logic [DATA_WIDTH-1:0] CORE_RESET_CMD = 64'hFFFF_FFFF_FFFF_FFFE;

  // Descriptor FIFO modes
  typedef enum logic {
    FIFO_FILL,
    FIFO_RUN
  } fifo_state_e;

endpackage
